//--- qdr_sniffer_defs.svh
`ifndef QDR_SNIFFER_DEFS_SVH
`define QDR_SNIFFER_DEFS_SVH

// ####################
// Memory geometry
// ####################

`define QDR_ADDR_WIDTH 10       // Word address bits.
`define QDR_DATA_WIDTH 36       // Two 18-bit beats per word.
`define QDR_BE_WIDTH   4        // Byte lanes of 9 bits each.

// Read command to read data valid, in cycles.
`define QDR_LATENCY    9

// ####################
// Host window
// ####################

// Base inclusive, high exclusive, one word per address.
`define HOST_BASE      32'h0000_4000
`define HOST_HIGH      32'h0000_4400

`endif

//--- qdr_sniffer_pkg.sv
package qdr_sniffer_pkg;

  // Arbiter states.
  typedef enum logic [1:0] {
    ARB_SLAVE         = 2'd0,   // Fabric slave owns the memory port.
    ARB_SLAVE_WAIT    = 2'd1,   // Let the last slave command drain.
    ARB_BACKDOOR      = 2'd2,   // One slot for the host.
    ARB_BACKDOOR_WAIT = 2'd3    // Recovery before the slave returns.
  } arb_state_t;

  // Command opcode on the backdoor and memory ports.
  typedef enum logic [1:0] {
    QDR_NOP   = 2'd0,
    QDR_READ  = 2'd1,
    QDR_WRITE = 2'd2
  } qdr_op_t;

endpackage

//--- qdr_host_port.sv
`timescale 1ns/1ps
`include "qdr_sniffer_defs.svh"

module qdr_host_port (
  input  logic                          qdr_clk,
  input  logic                          qdr_rst,
  input  logic                          host_en,
  input  logic                          host_rnw,
  input  logic [31:0]                   host_addr,
  input  logic [31:0]                   host_wdata,
  input  logic [3:0]                    host_be,
  output logic [31:0]                   host_rdata,
  output logic                          host_ack,
  output qdr_sniffer_pkg::qdr_op_t      backdoor_op,
  output logic [`QDR_ADDR_WIDTH-1:0]    backdoor_addr,
  output logic [`QDR_DATA_WIDTH-1:0]    backdoor_wdata,
  output logic [`QDR_BE_WIDTH-1:0]      backdoor_be,
  input  logic                          backdoor_grant,
  input  logic                          backdoor_rvld,
  input  logic [`QDR_DATA_WIDTH-1:0]    backdoor_rdata
);

  import qdr_sniffer_pkg::*;

  localparam int LANE_W = `QDR_DATA_WIDTH / `QDR_BE_WIDTH;

  logic                       in_window;
  logic [31:0]                offset;
  logic [`QDR_DATA_WIDTH-1:0] packed_wdata;
  logic                       rd_wait;
  logic                       busy;
  logic                       accept;

  assign in_window = (host_addr >= `HOST_BASE) && (host_addr < `HOST_HIGH);
  assign offset    = host_addr - `HOST_BASE;
  assign busy      = (backdoor_op != QDR_NOP) || rd_wait;
  assign accept    = host_en && in_window && !busy;   // Others are dropped.

  // Host byte i lands in lane i, top bit of the lane cleared.
  always_comb begin
    for (int i = 0; i < `QDR_BE_WIDTH; i++) begin
      packed_wdata[LANE_W*i +: LANE_W] = {1'b0, host_wdata[8*i +: 8]};
    end
  end

  // ####################
  // Request and acknowledge
  // ####################

  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      backdoor_op <= QDR_NOP;
      rd_wait     <= 1'b0;
      host_ack    <= 1'b0;
    end else begin
      host_ack <= 1'b0;
      if (accept) begin
        backdoor_op <= host_rnw ? QDR_READ : QDR_WRITE;
      end
      if (backdoor_grant) begin
        backdoor_op <= QDR_NOP;
        if (backdoor_op == QDR_WRITE) begin
          host_ack <= 1'b1;     // Write is done once issued.
        end else begin
          rd_wait <= 1'b1;
        end
      end
      if (rd_wait && backdoor_rvld) begin
        rd_wait  <= 1'b0;
        host_ack <= 1'b1;
      end
    end
  end

  always_ff @(posedge qdr_clk) begin
    if (accept) begin
      backdoor_addr  <= offset[`QDR_ADDR_WIDTH-1:0];
      backdoor_wdata <= packed_wdata;
      backdoor_be    <= host_be;
    end
    if (rd_wait && backdoor_rvld) begin
      for (int i = 0; i < `QDR_BE_WIDTH; i++) begin
        host_rdata[8*i +: 8] <= backdoor_rdata[LANE_W*i +: 8];
      end
    end
  end

endmodule

//--- qdr_arbiter.sv
`timescale 1ns/1ps
`include "qdr_sniffer_defs.svh"

module qdr_arbiter (
  input  logic                          qdr_clk,
  input  logic                          qdr_rst,
  // Fabric slave.
  input  logic [`QDR_ADDR_WIDTH-1:0]    slave_addr,
  input  logic                          slave_wr_strb,
  input  logic [`QDR_DATA_WIDTH-1:0]    slave_wr_data,
  input  logic [`QDR_BE_WIDTH-1:0]      slave_wr_be,
  input  logic                          slave_rd_strb,
  output logic                          slave_ack,
  output logic [`QDR_DATA_WIDTH-1:0]    slave_rd_data,
  output logic                          slave_rd_dvld,
  // Host backdoor.
  input  qdr_sniffer_pkg::qdr_op_t      backdoor_op,
  input  logic [`QDR_ADDR_WIDTH-1:0]    backdoor_addr,
  input  logic [`QDR_DATA_WIDTH-1:0]    backdoor_wdata,
  input  logic [`QDR_BE_WIDTH-1:0]      backdoor_be,
  output logic                          backdoor_grant,
  output logic [`QDR_DATA_WIDTH-1:0]    backdoor_rdata,
  output logic                          backdoor_rvld,
  // Memory master.
  output qdr_sniffer_pkg::qdr_op_t      mem_op,
  output logic [`QDR_ADDR_WIDTH-1:0]    mem_addr,
  output logic [`QDR_DATA_WIDTH-1:0]    mem_wdata,
  output logic [`QDR_BE_WIDTH-1:0]      mem_be,
  input  logic [`QDR_DATA_WIDTH-1:0]    mem_rdata,
  input  logic                          mem_rvld
);

  import qdr_sniffer_pkg::*;

  arb_state_t               state;
  logic [`QDR_LATENCY-1:0]  tag_pipe;     // Set where the read was the backdoor's.
  logic                     slave_strb;

  assign slave_strb = slave_wr_strb || slave_rd_strb;

  // ####################
  // Arbitration FSM
  // ####################

  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      state <= ARB_SLAVE;
    end else begin
      case (state)
        ARB_SLAVE: begin
          if (backdoor_op != QDR_NOP) begin
            state <= slave_strb ? ARB_SLAVE_WAIT : ARB_BACKDOOR;
          end
        end
        ARB_SLAVE_WAIT:    state <= ARB_BACKDOOR;
        ARB_BACKDOOR:      state <= ARB_BACKDOOR_WAIT;   // Single slot only.
        ARB_BACKDOOR_WAIT: state <= ARB_SLAVE;
        default:           state <= ARB_SLAVE;
      endcase
    end
  end

  assign slave_ack      = (state == ARB_SLAVE);
  assign backdoor_grant = (state == ARB_BACKDOOR);

  // Command mux onto the memory port.
  always_comb begin
    mem_op = QDR_NOP;
    if (slave_ack) begin
      if (slave_wr_strb) begin
        mem_op = QDR_WRITE;
      end else if (slave_rd_strb) begin
        mem_op = QDR_READ;
      end
    end else if (backdoor_grant) begin
      mem_op = backdoor_op;
    end
  end

  assign mem_addr  = backdoor_grant ? backdoor_addr  : slave_addr;
  assign mem_wdata = backdoor_grant ? backdoor_wdata : slave_wr_data;
  assign mem_be    = backdoor_grant ? backdoor_be    : slave_wr_be;

  // ####################
  // Read return steering
  // ####################

  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      tag_pipe <= '0;
    end else begin
      tag_pipe <= {tag_pipe[`QDR_LATENCY-2:0], backdoor_grant};
    end
  end

  assign slave_rd_dvld  = mem_rvld && !tag_pipe[`QDR_LATENCY-1];
  assign backdoor_rvld  = mem_rvld && tag_pipe[`QDR_LATENCY-1];
  assign slave_rd_data  = mem_rdata;
  assign backdoor_rdata = mem_rdata;

endmodule

//--- qdr_latency_store.sv
`timescale 1ns/1ps
`include "qdr_sniffer_defs.svh"

module qdr_latency_store (
  input  logic                          qdr_clk,
  input  logic                          qdr_rst,
  input  qdr_sniffer_pkg::qdr_op_t      mem_op,
  input  logic [`QDR_ADDR_WIDTH-1:0]    mem_addr,
  input  logic [`QDR_DATA_WIDTH-1:0]    mem_wdata,
  input  logic [`QDR_BE_WIDTH-1:0]      mem_be,
  output logic [`QDR_DATA_WIDTH-1:0]    mem_rdata,
  output logic                          mem_rvld
);

  import qdr_sniffer_pkg::*;

  localparam int LANE_W = `QDR_DATA_WIDTH / `QDR_BE_WIDTH;
  localparam int DEPTH  = 2 ** `QDR_ADDR_WIDTH;

  logic [`QDR_DATA_WIDTH-1:0] mem [DEPTH];
  logic [`QDR_DATA_WIDTH-1:0] rd_pipe [`QDR_LATENCY];
  logic [`QDR_LATENCY-1:0]    vld_pipe;

  // ####################
  // Storage and data pipe
  // ####################

  always_ff @(posedge qdr_clk) begin
    if (mem_op == QDR_WRITE) begin
      for (int i = 0; i < `QDR_BE_WIDTH; i++) begin
        if (mem_be[i]) begin
          mem[mem_addr][LANE_W*i +: LANE_W] <= mem_wdata[LANE_W*i +: LANE_W];
        end
      end
    end
  end

  // Looked up at issue, then delayed to the fixed latency.
  always_ff @(posedge qdr_clk) begin
    rd_pipe[0] <= mem[mem_addr];
    for (int i = 1; i < `QDR_LATENCY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  // ####################
  // Valid pipe
  // ####################

  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= {vld_pipe[`QDR_LATENCY-2:0], mem_op == QDR_READ};
    end
  end

  assign mem_rdata = rd_pipe[`QDR_LATENCY-1];
  assign mem_rvld  = vld_pipe[`QDR_LATENCY-1];   // One read per cycle in flight.

endmodule

//--- qdr_sniffer_top.sv
`timescale 1ns/1ps
`include "qdr_sniffer_defs.svh"

module qdr_sniffer_top (
  input  logic                          qdr_clk,
  input  logic                          qdr_rst,
  // Host.
  input  logic                          host_en,
  input  logic                          host_rnw,
  input  logic [31:0]                   host_addr,
  input  logic [31:0]                   host_wdata,
  input  logic [3:0]                    host_be,
  output logic [31:0]                   host_rdata,
  output logic                          host_ack,
  // Fabric slave.
  input  logic [`QDR_ADDR_WIDTH-1:0]    slave_addr,
  input  logic                          slave_wr_strb,
  input  logic [`QDR_DATA_WIDTH-1:0]    slave_wr_data,
  input  logic [`QDR_BE_WIDTH-1:0]      slave_wr_be,
  input  logic                          slave_rd_strb,
  output logic                          slave_ack,
  output logic [`QDR_DATA_WIDTH-1:0]    slave_rd_data,
  output logic                          slave_rd_dvld
);

  import qdr_sniffer_pkg::*;

  qdr_op_t                    backdoor_op;
  logic [`QDR_ADDR_WIDTH-1:0] backdoor_addr;
  logic [`QDR_DATA_WIDTH-1:0] backdoor_wdata;
  logic [`QDR_BE_WIDTH-1:0]   backdoor_be;
  logic                       backdoor_grant;
  logic                       backdoor_rvld;
  logic [`QDR_DATA_WIDTH-1:0] backdoor_rdata;

  qdr_op_t                    mem_op;
  logic [`QDR_ADDR_WIDTH-1:0] mem_addr;
  logic [`QDR_DATA_WIDTH-1:0] mem_wdata;
  logic [`QDR_BE_WIDTH-1:0]   mem_be;
  logic [`QDR_DATA_WIDTH-1:0] mem_rdata;
  logic                       mem_rvld;

  qdr_host_port qdr_host_port_inst (
    .qdr_clk        (qdr_clk),
    .qdr_rst        (qdr_rst),
    .host_en        (host_en),
    .host_rnw       (host_rnw),
    .host_addr      (host_addr),
    .host_wdata     (host_wdata),
    .host_be        (host_be),
    .host_rdata     (host_rdata),
    .host_ack       (host_ack),
    .backdoor_op    (backdoor_op),
    .backdoor_addr  (backdoor_addr),
    .backdoor_wdata (backdoor_wdata),
    .backdoor_be    (backdoor_be),
    .backdoor_grant (backdoor_grant),
    .backdoor_rvld  (backdoor_rvld),
    .backdoor_rdata (backdoor_rdata)
  );

  qdr_arbiter qdr_arbiter_inst (
    .qdr_clk        (qdr_clk),
    .qdr_rst        (qdr_rst),
    .slave_addr     (slave_addr),
    .slave_wr_strb  (slave_wr_strb),
    .slave_wr_data  (slave_wr_data),
    .slave_wr_be    (slave_wr_be),
    .slave_rd_strb  (slave_rd_strb),
    .slave_ack      (slave_ack),
    .slave_rd_data  (slave_rd_data),
    .slave_rd_dvld  (slave_rd_dvld),
    .backdoor_op    (backdoor_op),
    .backdoor_addr  (backdoor_addr),
    .backdoor_wdata (backdoor_wdata),
    .backdoor_be    (backdoor_be),
    .backdoor_grant (backdoor_grant),
    .backdoor_rdata (backdoor_rdata),
    .backdoor_rvld  (backdoor_rvld),
    .mem_op         (mem_op),
    .mem_addr       (mem_addr),
    .mem_wdata      (mem_wdata),
    .mem_be         (mem_be),
    .mem_rdata      (mem_rdata),
    .mem_rvld       (mem_rvld)
  );

  // Stands in for the QDR controller.
  qdr_latency_store qdr_latency_store_inst (
    .qdr_clk   (qdr_clk),
    .qdr_rst   (qdr_rst),
    .mem_op    (mem_op),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_be    (mem_be),
    .mem_rdata (mem_rdata),
    .mem_rvld  (mem_rvld)
  );

endmodule

//--- tb_qdr_sniffer.sv
`timescale 1ns/1ps
`include "qdr_sniffer_defs.svh"

module tb_qdr_sniffer;

  import qdr_sniffer_pkg::*;

  localparam int LANE_W  = `QDR_DATA_WIDTH / `QDR_BE_WIDTH;
  // Slave and host commands of the five phases, in order.
  localparam int N_TRANS = (64 + 64) + (32 + 64) + (4 * 3) + (80 + 3 * 2) + (4 * 4);

  logic qdr_clk, qdr_rst;
  logic host_en, host_rnw, host_ack;
  logic [31:0] host_addr, host_wdata, host_rdata;
  logic [3:0] host_be;
  logic [`QDR_ADDR_WIDTH-1:0] slave_addr;
  logic slave_wr_strb, slave_rd_strb, slave_ack, slave_rd_dvld;
  logic [`QDR_DATA_WIDTH-1:0] slave_wr_data, slave_rd_data;
  logic [`QDR_BE_WIDTH-1:0] slave_wr_be;

  logic [`QDR_DATA_WIDTH-1:0] ref_mem [int];
  logic [`QDR_DATA_WIDTH-1:0] rd_exp_q [$];
  int rd_cyc_q [$];
  int cycle, ack_low, lat, mismatches, failures, a;
  logic host_pend, host_pend_rnw;
  int host_pend_addr, host_t0;
  logic [`QDR_DATA_WIDTH-1:0] host_pend_data, exp_word;
  logic [3:0] host_pend_be;

  qdr_sniffer_top qdr_sniffer_top_inst (.*);

  always #10 qdr_clk = ~qdr_clk;

  task automatic report_mismatch(input string name, input logic [35:0] exp,
                                 input logic [35:0] act);
    mismatches++;
    $display("mismatch at %0d ns: %s expected %0h actual %0h", $time, name, exp, act);
  endtask

  task automatic report_failure(input string what);
    failures++;
    $display("error at %0d ns: %s", $time, what);
  endtask

  function automatic logic [35:0] pack_host(input logic [31:0] d);
    logic [35:0] w;
    for (int i = 0; i < 4; i++) begin
      w[LANE_W*i +: LANE_W] = {1'b0, d[8*i +: 8]};
    end
    return w;
  endfunction

  function automatic logic [31:0] unpack_word(input logic [35:0] w);
    logic [31:0] d;
    for (int i = 0; i < 4; i++) begin
      d[8*i +: 8] = w[LANE_W*i +: 8];
    end
    return d;
  endfunction

  function automatic logic [35:0] merge_lanes(input logic [35:0] old, input logic [35:0] d,
                                              input logic [3:0] be);
    logic [35:0] w;
    w = old;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        w[LANE_W*i +: LANE_W] = d[LANE_W*i +: LANE_W];
      end
    end
    return w;
  endfunction

  function automatic logic [35:0] rand_word();
    logic [63:0] r;
    r = {$urandom, $urandom};
    return r[35:0];
  endfunction

  function automatic int rand_addr(input int span);
    return int'($urandom % span);
  endfunction

  // ####################
  // Monitor and checks
  // ####################

  always @(posedge qdr_clk) begin
    cycle = cycle + 1;
    if (qdr_rst) begin
      ack_low = 0;
    end else begin
      ack_low = slave_ack ? 0 : ack_low + 1;
      assert (ack_low <= 3) else report_failure("slave_ack stayed low for more than 3 cycles");
      if (slave_ack && slave_wr_strb) begin
        ref_mem[int'(slave_addr)] = merge_lanes(ref_mem[int'(slave_addr)], slave_wr_data,
                                                slave_wr_be);
      end else if (slave_ack && slave_rd_strb) begin
        rd_exp_q.push_back(ref_mem[int'(slave_addr)]);
        rd_cyc_q.push_back(cycle);
      end
      if (slave_rd_dvld) begin
        assert (rd_exp_q.size() > 0) else report_failure("slave_rd_dvld with no slave read out");
        if (rd_exp_q.size() > 0) begin
          exp_word = rd_exp_q.pop_front();
          lat = cycle - rd_cyc_q.pop_front();
          assert (lat == `QDR_LATENCY)
            else report_mismatch("slave_rd_dvld latency", 36'(`QDR_LATENCY), 36'(lat));
          assert (slave_rd_data === exp_word)
            else report_mismatch("slave_rd_data", exp_word, slave_rd_data);
        end
      end
      if (host_ack) begin
        assert (host_pend) else report_failure("host_ack without an accepted host access");
        if (host_pend) begin
          lat = cycle - host_t0;
          if (host_pend_rnw) begin
            assert (lat == 12 || lat == 13)
              else report_mismatch("host_ack read latency", 36'(12), 36'(lat));
            assert (host_rdata === unpack_word(ref_mem[host_pend_addr]))
              else report_mismatch("host_rdata", 36'(unpack_word(ref_mem[host_pend_addr])),
                                   36'(host_rdata));
          end else begin
            assert (lat == 3 || lat == 4)
              else report_mismatch("host_ack write latency", 36'(3), 36'(lat));
            ref_mem[host_pend_addr] = merge_lanes(ref_mem[host_pend_addr], host_pend_data,
                                                  host_pend_be);
          end
          host_pend = 1'b0;
        end
      end
      if (host_en && !host_pend && host_addr >= `HOST_BASE && host_addr < `HOST_HIGH) begin
        host_pend      = 1'b1;
        host_pend_rnw  = host_rnw;
        host_pend_addr = int'(host_addr - `HOST_BASE);
        host_pend_data = pack_host(host_wdata);
        host_pend_be   = host_be;
        host_t0        = cycle;
      end
    end
  end

  // ####################
  // Stimulus
  // ####################

  task automatic slave_cmd(input logic wr, input int addr, input logic [35:0] d,
                           input logic [3:0] be);
    slave_addr    <= addr[`QDR_ADDR_WIDTH-1:0];
    slave_wr_strb <= wr;
    slave_rd_strb <= !wr;
    slave_wr_data <= d;
    slave_wr_be   <= be;
    @(negedge qdr_clk);
    while (!slave_ack) @(negedge qdr_clk);   // Held until granted.
    @(posedge qdr_clk);
  endtask

  task automatic slave_idle();
    slave_wr_strb <= 1'b0;
    slave_rd_strb <= 1'b0;
  endtask

  task automatic host_access(input logic rnw, input logic [31:0] addr, input logic [31:0] d,
                             input logic [3:0] be, input logic expect_ack);
    int n;
    logic got;
    n = 0;
    got = 1'b0;
    host_en    <= 1'b1;
    host_rnw   <= rnw;
    host_addr  <= addr;
    host_wdata <= d;
    host_be    <= be;
    @(posedge qdr_clk);
    host_en <= 1'b0;
    while (!got && n < 15) begin
      @(negedge qdr_clk);
      got = host_ack;
      n++;
    end
    assert (got || !expect_ack) else report_failure("host access in the window got no host_ack");
    assert (!got || expect_ack)
      else report_failure("host access outside the window was acknowledged");
    @(posedge qdr_clk);
  endtask

  task automatic drain();
    slave_idle();
    repeat (`QDR_LATENCY + 4) @(posedge qdr_clk);
  endtask

  initial begin
    logic [31:0] r;
    qdr_clk = 1'b0;
    qdr_rst = 1'b1;
    host_en = 1'b0;
    host_rnw = 1'b0;
    host_addr = '0;
    host_wdata = '0;
    host_be = '0;
    slave_addr = '0;
    slave_wr_strb = 1'b0;
    slave_rd_strb = 1'b0;
    slave_wr_data = '0;
    slave_wr_be = '0;
    cycle = 0;
    ack_low = 0;
    mismatches = 0;
    failures = 0;
    host_pend = 1'b0;
    void'($urandom(24299));
    repeat (4) @(posedge qdr_clk);
    qdr_rst <= 1'b0;
    @(negedge qdr_clk);
    assert (slave_ack === 1'b1) else report_mismatch("slave_ack", 36'(1), 36'(slave_ack));
    assert (host_ack === 1'b0) else report_mismatch("host_ack", 36'(0), 36'(host_ack));
    assert (slave_rd_dvld === 1'b0)
      else report_mismatch("slave_rd_dvld", 36'(0), 36'(slave_rd_dvld));
    @(posedge qdr_clk);
    for (int i = 0; i < 64; i++) begin
      slave_cmd(1'b1, i, rand_word(), 4'hf);   // Known contents.
    end
    repeat (64) slave_cmd(1'b0, rand_addr(64), '0, '0);   // Back to back reads.
    drain();
    repeat (32) begin
      r = $urandom;
      slave_cmd(1'b1, rand_addr(64), rand_word(), r[3:0]);
    end
    for (int i = 0; i < 64; i++) begin
      slave_cmd(1'b0, i, '0, '0);
    end
    drain();
    repeat (4) begin
      a = 32 + rand_addr(32);
      r = $urandom;
      host_access(1'b0, `HOST_BASE + a, $urandom, (r[3:0] == 4'h0) ? 4'hf : r[3:0], 1'b1);
      host_access(1'b1, `HOST_BASE + a, '0, '0, 1'b1);
      slave_cmd(1'b0, a, '0, '0);
      slave_idle();
    end
    drain();
    // Host uses the upper half while the slave runs in the lower half.
    fork
      begin
        repeat (80) begin
          r = $urandom;
          slave_cmd(r[0], rand_addr(32), rand_word(), r[4:1]);
        end
        slave_idle();
      end
      begin
        repeat (3) begin
          repeat (5) @(posedge qdr_clk);
          a = 32 + rand_addr(32);
          host_access(1'b0, `HOST_BASE + a, $urandom, 4'hf, 1'b1);
          host_access(1'b1, `HOST_BASE + a, '0, '0, 1'b1);
        end
      end
    join
    drain();
    repeat (4) begin
      a = rand_addr(64);
      host_access(1'b0, `HOST_HIGH + a, $urandom, 4'hf, 1'b0);
      host_access(1'b0, `HOST_BASE - 1 - a, $urandom, 4'hf, 1'b0);
      slave_cmd(1'b0, a, '0, '0);
      slave_cmd(1'b0, 1023 - a, '0, '0);
      slave_idle();
    end
    drain();
    assert (rd_exp_q.size() == 0) else report_failure("slave reads never returned data");
    $display("checks done: %0d mismatches, %0d other errors", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (N_TRANS * 20 + 200) @(posedge qdr_clk);
    $display("error at %0d ns: run did not finish in time", $time);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- qdr_sniffer.f
+incdir+.
qdr_sniffer_pkg.sv
qdr_host_port.sv
qdr_arbiter.sv
qdr_latency_store.sv
qdr_sniffer_top.sv
tb_qdr_sniffer.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the QDR sniffer testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_qdr_sniffer \
  -f qdr_sniffer.f -o tb_sim > build.log 2>&1 \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { cat build.log; echo "build or simulation run failed"; exit 1; }

cat sim.log
! grep -q "TEST RESULT: FAIL" sim.log \
  && grep -q "TEST RESULT: PASS" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
